/* build.f */
+incdir+source
source/mips_exec_pkg.sv
source/hilo_if.sv
source/exec_alu.sv
source/hilo_regs.sv
source/exec_stage.sv
tests/exec_checker.sv
tests/exec_stage_chk.sv
tests/exec_stage_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the log
rm -f sim.log
verilator --binary --assert --top-module exec_stage_tb -f build.f -o exec_stage_tb &&
  ./obj_dir/exec_stage_tb +verilator+error+limit+1000 > sim.log 2>&1
grep -q "PASS: all tests" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* source/exec_alu.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

module exec_alu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  mips_exec_pkg::instr_t instr,
  input  logic [`MIPS_XLEN-1:0] rs_content,
  input  logic [`MIPS_XLEN-1:0] rt_content,
  hilo_if.alu                   hilo,
  output logic                  result_valid,
  output logic [`MIPS_XLEN-1:0] alu_result,
  output logic                  sig_branch
);
  import mips_exec_pkg::*;

  instr_r_t                 r_f;
  instr_i_t                 i_f;
  logic [`MIPS_XLEN-1:0]    sign_ext;
  logic [`MIPS_XLEN-1:0]    zero_ext;
  logic [2*`MIPS_XLEN-1:0]  prod_s;
  logic [2*`MIPS_XLEN-1:0]  prod_u;
  logic [`MIPS_XLEN-1:0]    quot_s;
  logic [`MIPS_XLEN-1:0]    rem_s;
  logic [`MIPS_XLEN-1:0]    quot_u;
  logic [`MIPS_XLEN-1:0]    rem_u;
  logic                     div_ovf;
  logic [`MIPS_XLEN-1:0]    result_nx;
  logic                     branch_nx;
  logic                     muldiv;
  logic [`MIPS_XLEN-1:0]    hi_nx;
  logic [`MIPS_XLEN-1:0]    lo_nx;

  assign r_f = instr.r;
  assign i_f = instr.i;

  assign sign_ext = {{(`MIPS_XLEN-16){i_f.imm[15]}}, i_f.imm};
  assign zero_ext = {{(`MIPS_XLEN-16){1'b0}}, i_f.imm};

  assign prod_s = $signed({{`MIPS_XLEN{rs_content[`MIPS_XLEN-1]}}, rs_content}) *
                  $signed({{`MIPS_XLEN{rt_content[`MIPS_XLEN-1]}}, rt_content});
  assign prod_u = {{`MIPS_XLEN{1'b0}}, rs_content} * {{`MIPS_XLEN{1'b0}}, rt_content};

  // Most negative over minus one
  assign div_ovf = (rs_content == {1'b1, {(`MIPS_XLEN-1){1'b0}}}) && (rt_content == '1);

  always_comb
  begin
    if (rt_content == '0)
    begin
      quot_s = '1; // Divide by zero
      rem_s  = rs_content;
      quot_u = '1;
      rem_u  = rs_content;
    end
    else
    begin
      quot_u = rs_content / rt_content;
      rem_u  = rs_content % rt_content;
      if (div_ovf)
      begin
        quot_s = rs_content; // Saturates at the most negative value
        rem_s  = '0;
      end
      else
      begin
        quot_s = $signed(rs_content) / $signed(rt_content);
        rem_s  = $signed(rs_content) % $signed(rt_content);
      end
    end
  end

  always_comb
  begin
    result_nx = '0; // Unknown codes fall through as zero
    branch_nx = 1'b0;
    muldiv    = 1'b0;
    hi_nx     = '0;
    lo_nx     = '0;
    if (i_f.opcode == `OP_SPECIAL)
    begin
      case (r_f.funct)
        `FN_SLL:  result_nx = rt_content << r_f.shamt;
        `FN_SRL:  result_nx = rt_content >> r_f.shamt;
        `FN_SRA:  result_nx = $signed(rt_content) >>> r_f.shamt;
        `FN_SLLV: result_nx = rt_content << rs_content[4:0]; // Low five bits only
        `FN_SRLV: result_nx = rt_content >> rs_content[4:0];
        `FN_SRAV: result_nx = $signed(rt_content) >>> rs_content[4:0];
        `FN_MFHI: result_nx = hilo.hi; // Value before this edge
        `FN_MFLO: result_nx = hilo.lo;
        `FN_MULT:
        begin
          muldiv = 1'b1;
          hi_nx  = prod_s[2*`MIPS_XLEN-1:`MIPS_XLEN];
          lo_nx  = prod_s[`MIPS_XLEN-1:0];
        end
        `FN_MULTU:
        begin
          muldiv = 1'b1;
          hi_nx  = prod_u[2*`MIPS_XLEN-1:`MIPS_XLEN];
          lo_nx  = prod_u[`MIPS_XLEN-1:0];
        end
        `FN_DIV:
        begin
          muldiv = 1'b1;
          hi_nx  = rem_s;
          lo_nx  = quot_s;
        end
        `FN_DIVU:
        begin
          muldiv = 1'b1;
          hi_nx  = rem_u;
          lo_nx  = quot_u;
        end
        `FN_ADDU: result_nx = rs_content + rt_content;
        `FN_SUBU: result_nx = rs_content - rt_content;
        `FN_AND:  result_nx = rs_content & rt_content;
        `FN_OR:   result_nx = rs_content | rt_content;
        `FN_XOR:  result_nx = rs_content ^ rt_content;
        `FN_SLT:  result_nx[0] = $signed(rs_content) < $signed(rt_content);
        `FN_SLTU: result_nx[0] = rs_content < rt_content;
        default:  ;
      endcase
    end
    else
    begin
      case (i_f.opcode)
        `OP_ADDIU: result_nx = rs_content + sign_ext;
        `OP_ANDI:  result_nx = rs_content & zero_ext;
        `OP_ORI:   result_nx = rs_content | zero_ext;
        `OP_XORI:  result_nx = rs_content ^ zero_ext;
        `OP_LUI:   result_nx = {i_f.imm, 16'h0000};
        `OP_SLTI:  result_nx[0] = $signed(rs_content) < $signed(sign_ext);
        `OP_SLTIU: result_nx[0] = rs_content < sign_ext; // Unsigned against extended imm
        `OP_BEQ:
        begin
          result_nx = rs_content - rt_content; // Zero when equal
          branch_nx = (rs_content == rt_content);
        end
        `OP_BNE:   branch_nx = (rs_content != rt_content); // Result stays zero
        `OP_BLEZ:  branch_nx = rs_content[`MIPS_XLEN-1] || (rs_content == '0);
        `OP_BGTZ:  branch_nx = !rs_content[`MIPS_XLEN-1] && (rs_content != '0);
        `OP_REGIMM:
        begin
          case (i_f.rt)
            `RT_BLTZ, `RT_BLTZAL: branch_nx = rs_content[`MIPS_XLEN-1];
            `RT_BGEZ, `RT_BGEZAL: branch_nx = !rs_content[`MIPS_XLEN-1];
            default:              ;
          endcase
        end
        `OP_LB, `OP_LH, `OP_LW, `OP_LBU, `OP_LHU,
        `OP_SB, `OP_SH, `OP_SW:
          result_nx = rs_content + sign_ext; // Effective address
        default: ;
      endcase
    end
  end

  // HI/LO load on the issuing edge
  assign hilo.wr_en = issue_valid && muldiv;
  assign hilo.hi_wr = hi_nx;
  assign hilo.lo_wr = lo_nx;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_valid <= 1'b0;
      sig_branch   <= 1'b0;
      alu_result   <= '0;
    end
    else
    begin
      result_valid <= issue_valid; // One-cycle strobe
      sig_branch   <= issue_valid && branch_nx;
      if (issue_valid)
      begin
        alu_result <= result_nx;
      end
    end
  end

endmodule

/* source/exec_stage.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

module exec_stage (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  issue_valid,
  input  logic [31:0]           instr,
  input  logic [`MIPS_XLEN-1:0] rs_content,
  input  logic [`MIPS_XLEN-1:0] rt_content,
  output logic                  result_valid,
  output logic [`MIPS_XLEN-1:0] alu_result,
  output logic                  sig_branch,
  output logic [`MIPS_XLEN-1:0] hi,
  output logic [`MIPS_XLEN-1:0] lo
);
  import mips_exec_pkg::*;

  instr_t instr_u; // Raw word seen as R or I

  assign instr_u = instr_t'(instr);

  hilo_if i_hilo_if (
    .clk (clk)
  );

  exec_alu i_exec_alu (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .instr        (instr_u),
    .rs_content   (rs_content),
    .rt_content   (rt_content),
    .hilo         (i_hilo_if.alu),
    .result_valid (result_valid),
    .alu_result   (alu_result),
    .sig_branch   (sig_branch)
  );

  hilo_regs i_hilo_regs (
    .clk  (clk),
    .rst  (rst),
    .hilo (i_hilo_if.regs)
  );

  assign hi = i_hilo_if.hi; // Architectural HI/LO straight out
  assign lo = i_hilo_if.lo;

endmodule

/* source/hilo_if.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

interface hilo_if (
  input logic clk
);

  logic                  wr_en; // Multiply or divide issued
  logic [`MIPS_XLEN-1:0] hi_wr; // Remainder or product high half
  logic [`MIPS_XLEN-1:0] lo_wr; // Quotient or product low half
  logic [`MIPS_XLEN-1:0] hi;
  logic [`MIPS_XLEN-1:0] lo;

  modport alu (
    input  clk, hi, lo,
    output wr_en, hi_wr, lo_wr
  );

  modport regs (
    input  clk, wr_en, hi_wr, lo_wr,
    output hi, lo
  );

endinterface

/* source/hilo_regs.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

module hilo_regs (
  input logic  clk,
  input logic  rst,
  hilo_if.regs hilo
);

  logic [`MIPS_XLEN-1:0] hi_q; // Remainder or product high
  logic [`MIPS_XLEN-1:0] lo_q; // Quotient or product low

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      hi_q <= '0;
      lo_q <= '0;
    end
    else if (hilo.wr_en)
    begin
      hi_q <= hilo.hi_wr;
      lo_q <= hilo.lo_wr;
    end
  end

  // Always the current register value
  assign hilo.hi = hi_q;
  assign hilo.lo = lo_q;

endmodule

/* source/mips_exec_consts.svh */
`ifndef MIPS_EXEC_CONSTS_SVH
`define MIPS_EXEC_CONSTS_SVH

`define MIPS_XLEN 32 // Datapath width

`define OP_SPECIAL 6'h00 // R-type, funct decides
`define OP_REGIMM  6'h01 // Condition in rt field
`define OP_BEQ     6'h04
`define OP_BNE     6'h05
`define OP_BLEZ    6'h06
`define OP_BGTZ    6'h07
`define OP_ADDIU   6'h09
`define OP_SLTI    6'h0a
`define OP_SLTIU   6'h0b
`define OP_ANDI    6'h0c
`define OP_XORI    6'h0e
`define OP_LUI     6'h0f
`define OP_ORI     6'h13 // Team encoding, not the MIPS one
`define OP_LB      6'h20
`define OP_LH      6'h21
`define OP_LW      6'h23
`define OP_LBU     6'h24
`define OP_LHU     6'h25
`define OP_SB      6'h28
`define OP_SH      6'h29
`define OP_SW      6'h2b

`define FN_SLL     6'h00
`define FN_SRL     6'h02
`define FN_SRA     6'h03
`define FN_SLLV    6'h04
`define FN_SRLV    6'h06
`define FN_SRAV    6'h07
`define FN_MFHI    6'h10
`define FN_MFLO    6'h12
`define FN_MULT    6'h18
`define FN_MULTU   6'h19
`define FN_DIV     6'h1a
`define FN_DIVU    6'h1b
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23
`define FN_AND     6'h24
`define FN_OR      6'h25
`define FN_XOR     6'h26
`define FN_SLT     6'h2a
`define FN_SLTU    6'h2b

`define RT_BLTZ    5'h00
`define RT_BGEZ    5'h01
`define RT_BLTZAL  5'h10 // Link write not modelled
`define RT_BGEZAL  5'h11

`endif

/* source/mips_exec_pkg.sv */
package mips_exec_pkg;

  // Register format view
  typedef struct packed {
    logic [5:0] opcode;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd; // Destination, unused by the ALU
    logic [4:0] shamt; // Constant shift amount
    logic [5:0] funct; // Selects R-type operation
  } instr_r_t;

  // Immediate format view
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rs;
    logic [4:0]  rt; // REGIMM condition selector
    logic [15:0] imm; // Extended per opcode
  } instr_i_t;

  // Same 32-bit word, two decodes
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_t;

endpackage

/* tests/exec_checker.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

module exec_checker (
  input  logic                  clk,
  input  logic                  result_valid,
  input  logic [`MIPS_XLEN-1:0] alu_result,
  input  logic                  sig_branch,
  input  logic [`MIPS_XLEN-1:0] hi,
  input  logic [`MIPS_XLEN-1:0] lo,
  input  logic                  done,
  output int                    errors,
  output int                    results
);

  int          ids [$];
  logic [31:0] exp_res [$];
  logic [31:0] exp_br [$];
  logic [31:0] exp_hi [$];
  logic [31:0] exp_lo [$];
  int          err_cnt = 0;
  int          res_cnt = 0;
  int          cur_id = 0;
  int          n_tests = 0;
  int          n_checks = 0;
  int          test_checks = 0;
  int          test_errors = 0;
  logic        closed = 1'b0;

  assign errors  = err_cnt;
  assign results = res_cnt;

  initial
  begin
    int               fd;
    int               id;
    logic [31:0]      x;
    logic [31:0]      r;
    logic [31:0]      br;
    logic [31:0]      h;
    logic [31:0]      l;
    logic [8*160-1:0] line;
    fd = $fopen("tests/exec_stimulus.txt", "r");
    while (fd != 0 && $fgets(line, fd) > 0)
    begin
      if ($sscanf(line, "%d %h %h %h %h %h %h %h", id, x, x, x, r, br, h, l) == 8 && id != 0)
      begin
        ids.push_back(id); // Reset markers produce no result
        exp_res.push_back(r);
        exp_br.push_back(br);
        exp_hi.push_back(h);
        exp_lo.push_back(l);
      end
    end
    if (fd != 0)
      $fclose(fd);
  end

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    test_checks++;
    n_checks++;
    if (exp !== act)
    begin
      $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      err_cnt++;
      test_errors++;
    end
  endtask

  task automatic close_test();
    if (cur_id > 0)
    begin
      $display("test %0d done: %0d checks, %0d errors", cur_id, test_checks, test_errors);
      n_tests++;
    end
    test_checks = 0;
    test_errors = 0;
  endtask

  // Outputs and HI/LO are settled by the falling edge
  always @(negedge clk)
  begin
    if (result_valid)
    begin
      if (res_cnt >= ids.size())
      begin
        $display("error at %0t: result_valid with no operation left to compare", $time);
        err_cnt++;
      end
      else
      begin
        if (ids[res_cnt] != cur_id)
        begin
          close_test();
          cur_id = ids[res_cnt];
        end
        compare("alu_result", exp_res[res_cnt], alu_result);
        compare("sig_branch", exp_br[res_cnt], {31'b0, sig_branch});
        compare("hi", exp_hi[res_cnt], hi);
        compare("lo", exp_lo[res_cnt], lo);
      end
      res_cnt++;
    end
    if (done && !closed)
    begin
      close_test();
      $display("%0d tests, %0d results, %0d checks, %0d errors",
               n_tests, res_cnt, n_checks, err_cnt);
      closed = 1'b1;
    end
  end

endmodule

/* tests/exec_stage_chk.sv */
`timescale 1ns/10ps

module exec_stage_chk (
  input logic clk,
  input logic rst,
  input logic issue_valid,
  input logic result_valid,
  input logic sig_branch
);

  int fail_count = 0; // Read by the testbench at the end

  // Quiet while in reset and in the first cycle out of it
  assert property (@(posedge clk) rst |=> !result_valid && !sig_branch)
  else
  begin
    $error("result_valid or sig_branch high after a reset edge");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (rst) issue_valid |=> result_valid)
  else
  begin
    $error("result_valid missing one cycle after issue");
    fail_count++;
  end

  assert property (@(posedge clk) disable iff (rst) !issue_valid |=> !result_valid)
  else
  begin
    $error("result_valid without an issue");
    fail_count++;
  end

  assert property (@(posedge clk) sig_branch |-> result_valid)
  else
  begin
    $error("sig_branch high without result_valid");
    fail_count++;
  end

endmodule

bind exec_stage exec_stage_chk i_exec_stage_chk (
  .clk          (clk),
  .rst          (rst),
  .issue_valid  (issue_valid),
  .result_valid (result_valid),
  .sig_branch   (sig_branch)
);

/* tests/exec_stage_tb.sv */
`timescale 1ns/10ps
`include "mips_exec_consts.svh"

module exec_stage_tb;

  logic                  clk;
  logic                  rst;
  logic                  issue_valid;
  logic [31:0]           instr;
  logic [`MIPS_XLEN-1:0] rs_content;
  logic [`MIPS_XLEN-1:0] rt_content;
  logic                  result_valid;
  logic [`MIPS_XLEN-1:0] alu_result;
  logic                  sig_branch;
  logic [`MIPS_XLEN-1:0] hi;
  logic [`MIPS_XLEN-1:0] lo;
  logic                  done;
  logic                  loaded;
  int                    errors;
  int                    results;
  int                    n_ops;
  int                    n_resets;
  int                    seed;
  int                    ids [$];
  logic [31:0]           instrs [$];
  logic [31:0]           rs_vals [$];
  logic [31:0]           rt_vals [$];

  exec_stage i_exec_stage (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .instr        (instr),
    .rs_content   (rs_content),
    .rt_content   (rt_content),
    .result_valid (result_valid),
    .alu_result   (alu_result),
    .sig_branch   (sig_branch),
    .hi           (hi),
    .lo           (lo)
  );

  exec_checker i_exec_checker (
    .clk          (clk),
    .result_valid (result_valid),
    .alu_result   (alu_result),
    .sig_branch   (sig_branch),
    .hi           (hi),
    .lo           (lo),
    .done         (done),
    .errors       (errors),
    .results      (results)
  );

  always #4 clk = ~clk; // 8 ns period

  task automatic load_stimulus();
    int               fd;
    int               id;
    logic [31:0]      w;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      x;
    logic [8*160-1:0] line;
    fd = $fopen("tests/exec_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("could not open tests/exec_stimulus.txt");
      return;
    end
    while ($fgets(line, fd) > 0)
    begin
      if ($sscanf(line, "%d %h %h %h %h %h %h %h", id, w, a, b, x, x, x, x) == 8)
      begin
        ids.push_back(id);
        instrs.push_back(w);
        rs_vals.push_back(a);
        rt_vals.push_back(b);
        if (id == 0)
          n_resets++;
        else
          n_ops++;
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    clk         = 1'b0;
    rst         = 1'b1;
    issue_valid = 1'b0;
    instr       = '0;
    rs_content  = '0;
    rt_content  = '0;
    done        = 1'b0;
    loaded      = 1'b0;
    n_ops       = 0;
    n_resets    = 0;
    seed        = 98282;
    load_stimulus();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    foreach (ids[k])
    begin
      @(posedge clk);
      if (ids[k] == 0) // Reset lands while the last issue is still driven
      begin
        rst <= 1'b1;
        repeat (2) @(posedge clk);
        rst         <= 1'b0;
        issue_valid <= 1'b0;
      end
      else
      begin
        issue_valid <= 1'b1;
        instr       <= instrs[k];
        rs_content  <= rs_vals[k];
        rt_content  <= rt_vals[k];
        if (ids[k] != 6 && ($random(seed) & 3) == 0) // Test 6 stays back-to-back
        begin
          @(posedge clk);
          issue_valid <= 1'b0;
        end
      end
    end
    @(posedge clk);
    issue_valid <= 1'b0;
    repeat (2) @(posedge clk);
    done <= 1'b1;
    repeat (2) @(posedge clk);
    if (errors == 0 && results == n_ops && n_ops > 0 &&
        i_exec_stage.i_exec_stage_chk.fail_count == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      if (results != n_ops || n_ops == 0)
        $display("%0d results seen for %0d issued operations", results, n_ops);
      if (i_exec_stage.i_exec_stage_chk.fail_count != 0)
        $display("%0d assertion failures", i_exec_stage.i_exec_stage_chk.fail_count);
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Every line may add one idle cycle, resets add three
  initial
  begin
    int cycles;
    wait (loaded);
    cycles = 2 * ids.size() + 3 * n_resets + 8 + 20;
    #(cycles * 8);
    $display("timeout: stimulus did not complete within %0d cycles", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* tests/exec_stimulus.txt */
// id instr rs rt result branch hi lo, all hex except the decimal id
// An id of 0 pulses reset instead of issuing, hi and lo are the values after the operation
1 00000021 7fffffff 00000001 80000000 0 00000000 00000000
1 00000023 00000005 00000007 fffffffe 0 00000000 00000000
1 00000024 f0f0ffff 0ff0f00f 00f0f00f 0 00000000 00000000
1 00000026 ffff0000 0ff00ff0 f00f0ff0 0 00000000 00000000
1 0000002a ffffffff 00000001 00000001 0 00000000 00000000
1 0000002b ffffffff 00000001 00000000 0 00000000 00000000
2 00000100 00000000 0000000f 000000f0 0 00000000 00000000
2 00000202 00000000 80000000 00800000 0 00000000 00000000
2 00000103 00000000 80000000 f8000000 0 00000000 00000000
2 00000004 00000023 00000001 00000008 0 00000000 00000000
2 00000006 00000024 f0000000 0f000000 0 00000000 00000000
2 00000007 00000004 f0000000 ff000000 0 00000000 00000000
3 2400fffe 00000010 00000000 0000000e 0 00000000 00000000
3 2800ffff fffffffe 00000000 00000001 0 00000000 00000000
3 2c00ffff 00000005 00000000 00000001 0 00000000 00000000
3 3000ff00 ffffffff 00000000 0000ff00 0 00000000 00000000
3 4c008000 12340000 00000000 12348000 0 00000000 00000000
3 3800ffff ffff0000 00000000 ffffffff 0 00000000 00000000
3 3c00abcd 00000000 00000000 abcd0000 0 00000000 00000000
3 8c00fffc 00001000 00000000 00000ffc 0 00000000 00000000
4 10000000 00000005 00000005 00000000 1 00000000 00000000
4 10000000 00000005 00000003 00000002 0 00000000 00000000
4 14000000 00000005 00000003 00000000 1 00000000 00000000
4 18000000 00000000 00000000 00000000 1 00000000 00000000
4 1c000000 00000001 00000000 00000000 1 00000000 00000000
4 04000000 ffffffff 00000001 00000000 1 00000000 00000000
4 04010000 00000000 ffffffff 00000000 1 00000000 00000000
4 04100000 00000003 ffffffff 00000000 0 00000000 00000000
4 04110000 80000000 00000000 00000000 0 00000000 00000000
5 00000018 fffffffe 00000003 00000000 0 ffffffff fffffffa
5 00000010 00000000 00000000 ffffffff 0 ffffffff fffffffa
5 00000019 fffffffe 00000003 00000000 0 00000002 fffffffa
5 00000012 00000000 00000000 fffffffa 0 00000002 fffffffa
5 0000001a fffffff9 00000002 00000000 0 ffffffff fffffffd
5 0000001b 00000007 00000002 00000000 0 00000001 00000003
5 0000001a 00000009 00000000 00000000 0 00000009 ffffffff
5 0000001a 80000000 ffffffff 00000000 0 00000000 80000000
5 00000012 00000000 00000000 80000000 0 00000000 80000000
6 00000019 00010000 00010000 00000000 0 00000001 00000000
6 00000010 00000000 00000000 00000001 0 00000001 00000000
0 00000000 00000000 00000000 00000000 0 00000000 00000000
6 00000010 00000000 00000000 00000000 0 00000000 00000000
6 00000012 00000000 00000000 00000000 0 00000000 00000000
6 ffffffff 12345678 00000001 00000000 0 00000000 00000000
